// ==== source/sdram_pkg.sv ====
// shared definitions for the sdram controller
// command codes, slot states, address split and init length
// sd_addr pin word union with row, column and mode views

package sdram_pkg;

	// --------------------
	// commands, {cs, ras, cas, we}
	typedef enum logic [3:0] {
		CMD_INHIBIT      = 4'b1111,
		CMD_NOP          = 4'b0111,
		CMD_ACTIVE       = 4'b0011,
		CMD_READ         = 4'b0101,
		CMD_WRITE        = 4'b0100,
		CMD_PRECHARGE    = 4'b0010,
		CMD_AUTO_REFRESH = 4'b0001,
		CMD_LOAD_MODE    = 4'b0000
	} sdram_cmd_t;

	// --------------------
	// 8 state access slot
	typedef logic [2:0] slot_t;
	localparam slot_t SLOT_ACT  = 3'd1;	// row open
	localparam slot_t SLOT_CMD  = 3'd3;	// read/write with auto precharge
	localparam slot_t SLOT_LAST = 3'd7;	// done, wraps to 0

	// host word address is {bank, row, col}
	localparam int ROW_BITS  = 13;
	localparam int COL_BITS  = 9;
	localparam int BANK_BITS = 2;
	localparam int ADDR_BITS = 24;

	localparam int INIT_SLOTS = 16;	// slots spent in power-up sequence

	// --------------------
	// sd_addr pin word views
	typedef struct packed {
		logic [1:0]          zero_hi;	// a12..a11
		logic                auto_pre;	// a10, also precharge-all
		logic                zero_9;
		logic [COL_BITS-1:0] col;
	} sd_col_t;

	typedef struct packed {
		logic [2:0] reserved;
		logic       write_burst;	// 1 = single location writes
		logic [1:0] op_mode;	// standard operation only
		logic [2:0] cas_lat;
		logic       burst_type;	// 0 = sequential
		logic [2:0] burst_len;	// 000 = one word
	} sd_mode_t;

	typedef union packed {
		logic [ROW_BITS-1:0] row;
		sd_col_t             col;
		sd_mode_t            mode;
	} sd_addr_u;

endpackage

// ==== source/sdram_req_if.sv ====
// single host request between the bus port and the slot logic
// modports for the bus port, the sequencer and the datapath blocks

`timescale 1ns/10ps

interface sdram_req_if import sdram_pkg::*; ();

	logic                 valid;	// request pending, held until done
	logic                 we;
	logic [ADDR_BITS-1:0] addr;	// word address
	logic [15:0]          wdata;
	logic [1:0]           sel;	// byte selects, bit 1 = upper byte
	logic                 done;	// one cycle, in last slot state
	logic [15:0]          rdata;

	// bus side owns the request, gets completion back
	modport port (output valid, we, addr, wdata, sel, input done, rdata);

	// slot control only needs the pending flag and direction
	modport seq (input valid, we, output done);

	// address mux and data path
	modport dp (input addr, wdata, sel, we, output rdata);

endinterface

// ==== source/sdram_wb_port.sv ====
// wishbone classic slave front end
// latches one bus cycle into the request, returns data with a single ack

`timescale 1ns/10ps

module sdram_wb_port import sdram_pkg::*; (
	input  logic                 clk_64,
	input  logic                 reset,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [ADDR_BITS-1:0] wb_adr,
	input  logic [15:0]          wb_dat_w,
	input  logic [1:0]           wb_sel,
	output logic [15:0]          wb_dat_r,
	output logic                 wb_ack,
	sdram_req_if.port            req
);

	logic new_cycle;

	// master holds stb until ack, so skip the ack cycle itself
	assign new_cycle = wb_cyc && wb_stb && !req.valid && !wb_ack;

	// --------------------
	// request hold and ack
	always_ff @(posedge clk_64) begin
		if (reset) begin
			req.valid <= 1'b0;
			wb_ack    <= 1'b0;
		end else begin
			wb_ack <= 1'b0;	// single cycle pulse
			if (req.valid && req.done) begin
				req.valid <= 1'b0;	// slot finished
				wb_ack    <= 1'b1;
			end else if (new_cycle) begin
				req.valid <= 1'b1;
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk_64) begin
		if (new_cycle) begin
			req.we    <= wb_we;
			req.addr  <= wb_adr;
			req.wdata <= wb_dat_w;
			req.sel   <= wb_sel;
		end
		if (req.done)
			wb_dat_r <= req.rdata;	// captured in state 3 + CL, stable here
	end

	// ack only ever answers a live bus cycle
	a_ack_in_cycle: assert property (@(posedge clk_64) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

// ==== source/sdram_sequencer.sv ====
// slot sequencer, the control part of the controller
// free running 8 state slot counter
// per slot choice of init command, auto refresh or host access
// command, write drive and read capture strobes, request done

`timescale 1ns/10ps

module sdram_sequencer import sdram_pkg::*; #(
	parameter int CAS_LATENCY = 3
) (
	input  logic       clk_64,
	input  logic       reset,
	sdram_req_if.seq   req,
	input  logic       init_done,
	input  sdram_cmd_t init_cmd,
	input  logic       refresh_due,
	output logic       slot_end,
	output logic       refresh_taken,
	output sdram_cmd_t cmd,	// registered onto the pins next cycle
	output slot_t      slot,
	output logic       drive,	// write data onto the pins next cycle
	output logic       capture	// sample the data pins at this edge
);

	// cmd is one cycle ahead of the pins, so decide in the state before
	localparam slot_t SLOT_DECIDE  = slot_t'(SLOT_ACT - 3'd1);
	localparam slot_t SLOT_PRE_CMD = slot_t'(SLOT_CMD - 3'd1);
	localparam slot_t SLOT_CAPTURE = slot_t'(SLOT_CMD + CAS_LATENCY);
	localparam slot_t SLOT_DONE    = slot_t'(SLOT_LAST - 3'd1);

	logic take_access;
	logic slot_access;	// current slot serves the host
	logic slot_refresh;	// current slot is a normal auto refresh

	// --------------------
	// slot counter
	always_ff @(posedge clk_64) begin
		if (reset)
			slot <= '0;
		else
			slot <= slot + 3'd1;	// wraps 7 -> 0
	end

	assign slot_end = (slot == SLOT_LAST);

	// host gets the slot only when nothing else needs it
	assign take_access = (slot == SLOT_DECIDE) && req.valid && init_done && !refresh_due;

	// every non host slot after init refreshes, which also restarts the timer
	assign refresh_taken = (slot == SLOT_DECIDE) && init_done && !take_access;

	// --------------------
	// slot kind, held for the whole slot
	always_ff @(posedge clk_64) begin
		if (reset) begin
			slot_access  <= 1'b0;
			slot_refresh <= 1'b0;
		end else if (slot == SLOT_DECIDE) begin
			slot_access  <= take_access;
			slot_refresh <= refresh_taken;
		end
	end

	// --------------------
	// command for the next state
	always_comb begin
		cmd = CMD_NOP;
		if (slot == SLOT_DECIDE) begin
			if (take_access)
				cmd = CMD_ACTIVE;
			else if (init_done)
				cmd = CMD_AUTO_REFRESH;
			else
				cmd = init_cmd;	// power-up schedule, mostly nop
		end else if (slot == SLOT_PRE_CMD && slot_access) begin
			cmd = req.we ? CMD_WRITE : CMD_READ;	// auto precharge set by the mux
		end
	end

	assign drive   = slot_access && req.we && (slot == SLOT_PRE_CMD);
	assign capture = slot_access && !req.we && (slot == SLOT_CAPTURE);

	// done lands in the last state, rdata already valid
	always_ff @(posedge clk_64) begin
		if (reset)
			req.done <= 1'b0;
		else
			req.done <= slot_access && (slot == SLOT_DONE);
	end

	// init sequence has to be complete before any host slot finishes
	a_done_after_init: assert property (@(posedge clk_64) disable iff (reset)
		req.done |-> init_done);

	// a refresh slot never completes a request
	a_no_done_in_refresh: assert property (@(posedge clk_64) disable iff (reset)
		req.done |-> !slot_refresh);

endmodule

// ==== source/sdram_addr_mux.sv ====
// address pin builder
// registers command, bank and the 13 bit pin word per command

`timescale 1ns/10ps

module sdram_addr_mux import sdram_pkg::*; #(
	parameter int CAS_LATENCY = 3
) (
	input  logic                 clk_64,
	input  logic                 reset,
	input  sdram_cmd_t           cmd,
	input  slot_t                slot,
	sdram_req_if.dp              req,
	output logic [ROW_BITS-1:0]  sd_addr,
	output logic [BANK_BITS-1:0] sd_ba,
	output sdram_cmd_t           sd_cmd
);

	sd_addr_u pin_word;

	// --------------------
	// pin word per command
	always_comb begin
		pin_word = '0;
		case (cmd)
			CMD_ACTIVE: pin_word.row = req.addr[COL_BITS +: ROW_BITS];
			CMD_READ, CMD_WRITE: begin
				pin_word.col.auto_pre = 1'b1;	// close the row at the end
				pin_word.col.col      = req.addr[COL_BITS-1:0];
			end
			CMD_LOAD_MODE: begin
				pin_word.mode.write_burst = 1'b1;	// single writes
				pin_word.mode.cas_lat     = 3'(CAS_LATENCY);
			end
			CMD_PRECHARGE: pin_word.col.auto_pre = 1'b1;	// a10 = all banks
			default: ;
		endcase
	end

	always_ff @(posedge clk_64) begin
		if (reset)
			sd_cmd <= CMD_INHIBIT;
		else
			sd_cmd <= cmd;
	end

	// bank follows the request and only matters at active and read/write
	always_ff @(posedge clk_64) begin
		sd_addr <= pin_word;
		sd_ba   <= req.addr[ADDR_BITS-1 -: BANK_BITS];
	end

	// row open and column command only in their slot states
	a_cmd_in_slot: assert property (@(posedge clk_64) disable iff (reset)
		(sd_cmd == CMD_ACTIVE) |-> (slot == SLOT_ACT));

	a_col_in_slot: assert property (@(posedge clk_64) disable iff (reset)
		(sd_cmd == CMD_READ || sd_cmd == CMD_WRITE) |-> (slot == SLOT_CMD));

endmodule

// ==== source/sdram_data_path.sv ====
// data pins of the sdram
// write data and byte masks during the write command, read capture

`timescale 1ns/10ps

module sdram_data_path #(
	parameter int CAS_LATENCY = 3
) (
	input  logic        clk_64,
	input  logic        reset,
	input  logic        drive,
	input  logic        capture,
	input  logic [15:0] sd_dq_in,
	sdram_req_if.dp     req,
	output logic [15:0] sd_dq_out,
	output logic        sd_dq_oe,
	output logic [1:0]  sd_dqm
);

	// --------------------
	// write side
	always_ff @(posedge clk_64) begin
		if (reset)
			sd_dq_oe <= 1'b0;
		else
			sd_dq_oe <= drive;	// same cycle as the write command on the pins
	end

	always_ff @(posedge clk_64) begin
		sd_dq_out <= req.wdata;
		// masks only matter for writes, reads always return both bytes
		if (drive && req.we)
			sd_dqm <= ~req.sel;
		else
			sd_dqm <= 2'b00;
	end

	// --------------------
	// read side
	always_ff @(posedge clk_64) begin
		if (capture)
			req.rdata <= sd_dq_in;	// CL edges after the read command
	end

	// bus turnaround, the chip is driving when capture is up
	a_no_oe_on_capture: assert property (@(posedge clk_64) disable iff (reset)
		capture |-> !sd_dq_oe);

	// nor was a write on the pins when the read command went out
	a_read_cmd_clear: assert property (@(posedge clk_64) disable iff (reset)
		capture |-> $past(!sd_dq_oe, CAS_LATENCY));

endmodule

// ==== source/sdram_init_refresh.sv ====
// power-up command schedule and refresh timer
// init counts slots down, then a slot timer asks for refreshes

`timescale 1ns/10ps

module sdram_init_refresh import sdram_pkg::*; #(
	parameter int REFRESH_SLOTS = 48
) (
	input  logic       clk_64,
	input  logic       reset,
	input  logic       slot_end,
	input  logic       refresh_taken,
	output logic       init_done,
	output sdram_cmd_t init_cmd,
	output logic       refresh_due
);

	localparam int INIT_W = $clog2(INIT_SLOTS + 1);
	localparam int REF_W  = $clog2(REFRESH_SLOTS + 1);

	logic [INIT_W-1:0] init_cnt;	// slots left in power-up
	logic [REF_W-1:0]  ref_cnt;	// slots since last refresh

	// --------------------
	// init countdown
	always_ff @(posedge clk_64) begin
		if (reset)
			init_cnt <= INIT_W'(INIT_SLOTS);
		else if (slot_end && init_cnt != '0)
			init_cnt <= init_cnt - 1'b1;
	end

	assign init_done = (init_cnt == '0);

	always_comb begin
		case (init_cnt)
			INIT_W'(13):             init_cmd = CMD_PRECHARGE;
			INIT_W'(10), INIT_W'(7): init_cmd = CMD_AUTO_REFRESH;
			INIT_W'(2):              init_cmd = CMD_LOAD_MODE;
			default:                 init_cmd = CMD_NOP;
		endcase
	end

	// --------------------
	// refresh timer, saturates until a refresh slot is issued
	always_ff @(posedge clk_64) begin
		if (reset || refresh_taken)
			ref_cnt <= '0;
		else if (init_done && slot_end && ref_cnt != REF_W'(REFRESH_SLOTS))
			ref_cnt <= ref_cnt + 1'b1;
	end

	assign refresh_due = (ref_cnt == REF_W'(REFRESH_SLOTS));

endmodule

// ==== source/sdram_top.sv ====
// sdram controller top level
// wishbone classic slave on one side, split data pins on the chip side
// bus port, sequencer, init/refresh, address mux and data path

`timescale 1ns/10ps

module sdram_top import sdram_pkg::*; #(
	parameter int CAS_LATENCY   = 3,	// 2 or 3
	parameter int REFRESH_SLOTS = 48	// slots between forced refreshes
) (
	input  logic                 clk_64,
	input  logic                 reset,
	// wishbone
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [ADDR_BITS-1:0] wb_adr,
	input  logic [15:0]          wb_dat_w,
	input  logic [1:0]           wb_sel,
	output logic [15:0]          wb_dat_r,
	output logic                 wb_ack,
	// sdram chip
	input  logic [15:0]          sd_dq_in,
	output logic [15:0]          sd_dq_out,
	output logic                 sd_dq_oe,
	output logic [ROW_BITS-1:0]  sd_addr,
	output logic [BANK_BITS-1:0] sd_ba,
	output logic [1:0]           sd_dqm,
	output logic                 sd_cs,
	output logic                 sd_ras,
	output logic                 sd_cas,
	output logic                 sd_we
);

	sdram_cmd_t cmd, init_cmd, sd_cmd;
	slot_t      slot;
	logic       init_done, refresh_due, slot_end, refresh_taken;
	logic       drive, capture;

	sdram_req_if req ();

	assign {sd_cs, sd_ras, sd_cas, sd_we} = sd_cmd;	// command bits straight to pins

	sdram_wb_port i_wb_port (.clk_64, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
		.wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack, .req(req.port));

	sdram_sequencer #(.CAS_LATENCY(CAS_LATENCY)) i_sequencer (.clk_64, .reset,
		.req(req.seq), .init_done, .init_cmd, .refresh_due, .slot_end, .refresh_taken,
		.cmd, .slot, .drive, .capture);

	sdram_init_refresh #(.REFRESH_SLOTS(REFRESH_SLOTS)) i_init_refresh (.clk_64, .reset,
		.slot_end, .refresh_taken, .init_done, .init_cmd, .refresh_due);

	sdram_addr_mux #(.CAS_LATENCY(CAS_LATENCY)) i_addr_mux (.clk_64, .reset, .cmd,
		.slot, .req(req.dp), .sd_addr, .sd_ba, .sd_cmd);

	sdram_data_path #(.CAS_LATENCY(CAS_LATENCY)) i_data_path (.clk_64, .reset, .drive,
		.capture, .sd_dq_in, .req(req.dp), .sd_dq_out, .sd_dq_oe, .sd_dqm);

endmodule

// ==== tests/sdram_chip_model.sv ====
// behavioural sdram chip for the testbench
// command decode, open rows per bank, byte masked writes
// read data after cas latency, protocol and refresh counters

`timescale 1ns/10ps

module sdram_chip_model #(
	parameter int CAS_LATENCY = 3
) (
	input  logic        clk_64,
	input  logic        cs,
	input  logic        ras,
	input  logic        cas,
	input  logic        we,
	input  logic [1:0]  ba,
	input  logic [12:0] addr,
	input  logic [1:0]  dqm,
	input  logic [15:0] dq_in,
	output logic [15:0] dq_out,
	output logic        dq_oe
);

	// datasheet command truth table, all pins active low
	localparam logic [3:0] C_ACTIVE    = 4'b0011;
	localparam logic [3:0] C_READ      = 4'b0101;
	localparam logic [3:0] C_WRITE     = 4'b0100;
	localparam logic [3:0] C_PRECHARGE = 4'b0010;
	localparam logic [3:0] C_REFRESH   = 4'b0001;
	localparam logic [3:0] C_LOAD_MODE = 4'b0000;

	logic [15:0]            mem [logic [23:0]];	// sparse, keyed by {bank, row, col}
	logic [12:0]            open_row [4];
	logic [3:0]             row_open = '0;
	logic [CAS_LATENCY-1:0] rd_pipe = '0;	// one bit per edge since the read
	logic [15:0]            rd_word = '0;
	logic [12:0]            mode_word = '0;
	logic                   gap_armed = 1'b0;	// set from the first refresh after load-mode
	int                     n_precharge_all = 0;
	int                     n_refresh = 0;
	int                     n_load_mode = 0;
	int                     n_bad_seq = 0;	// commands against the row state
	int                     refresh_gap = 0;	// cycles since last auto refresh
	int                     max_refresh_gap = 0;

	assign dq_oe  = rd_pipe[CAS_LATENCY-1];	// valid at edge read + CL
	assign dq_out = rd_word;

	always @(posedge clk_64) begin
		logic [23:0] wa;
		logic [15:0] word;
		wa   = {ba, open_row[ba], addr[8:0]};
		word = mem.exists(wa) ? mem[wa] : 16'h0000;
		rd_pipe <= {rd_pipe[CAS_LATENCY-2:0], 1'b0};
		case ({cs, ras, cas, we})
			C_ACTIVE: begin
				if (row_open[ba])
					n_bad_seq <= n_bad_seq + 1;	// no precharge since last active
				row_open[ba] <= 1'b1;
				open_row[ba] <= addr;
			end
			C_READ, C_WRITE: begin
				if (!row_open[ba])
					n_bad_seq <= n_bad_seq + 1;
				if (addr[10])
					row_open[ba] <= 1'b0;	// auto precharge
				if (!we) begin
					if (!dqm[0])
						word[7:0] = dq_in[7:0];
					if (!dqm[1])
						word[15:8] = dq_in[15:8];
					mem[wa] = word;
				end else begin
					rd_pipe[0] <= 1'b1;
					rd_word    <= word;
				end
			end
			C_PRECHARGE: begin
				if (addr[10]) begin
					n_precharge_all <= n_precharge_all + 1;
					row_open        <= '0;
				end else
					row_open[ba] <= 1'b0;
			end
			C_REFRESH: begin
				if (row_open != '0)
					n_bad_seq <= n_bad_seq + 1;	// refresh needs all banks idle
				n_refresh <= n_refresh + 1;
				if (gap_armed && refresh_gap > max_refresh_gap)
					max_refresh_gap <= refresh_gap;
				gap_armed <= (n_load_mode > 0);
			end
			C_LOAD_MODE: begin
				n_load_mode <= n_load_mode + 1;
				mode_word   <= addr;
			end
			default: ;	// nop, inhibit
		endcase
		refresh_gap <= ({cs, ras, cas, we} == C_REFRESH) ? 1 : refresh_gap + 1;
	end

endmodule

// ==== tests/sdram_top_tb.sv ====
// testbench for the sdram controller
// clock and reset, xorshift driven wishbone master, reference memory
// pin monitors for address, bus ownership and refresh spacing, final report

`timescale 1ns/10ps

module sdram_top_tb;

	localparam int CAS_LATENCY   = 3;
	localparam int REFRESH_SLOTS = 48;
	localparam int POOL_SIZE     = 8;	// kept small so reads hit written words
	localparam int N_OPS         = 400;
	localparam int ACK_TIMEOUT   = 400;	// in cycles, long enough for the init phase
	localparam logic [3:0] C_ACTIVE = 4'b0011;	// {cs, ras, cas, we}
	localparam logic [3:0] C_READ   = 4'b0101;
	localparam logic [3:0] C_WRITE  = 4'b0100;

	logic        clk_64 = 1'b0;
	logic        reset;
	logic        wb_cyc, wb_stb, wb_we, wb_ack;
	logic [23:0] wb_adr;
	logic [15:0] wb_dat_w, wb_dat_r;
	logic [1:0]  wb_sel, sd_ba, sd_dqm;
	logic [15:0] sd_dq_out, chip_dq, dq_bus;
	logic        sd_dq_oe, chip_oe, sd_cs, sd_ras, sd_cas, sd_we;
	logic [12:0] sd_addr;
	logic [3:0]  pin_cmd;

	logic [31:0] rng_state = 32'd80;
	logic [23:0] pool_adr [POOL_SIZE];
	logic [15:0] ref_mem [POOL_SIZE];	// expected contents of the pooled words
	logic [23:0] cur_adr = '0;	// request on the bus
	logic        cur_we = 1'b0;
	logic        timed_out = 1'b0;
	logic        mode_checked = 1'b0;
	int          n_checks = 0;
	int          n_errors = 0;

	// tristate data bus with a high idle level
	assign dq_bus  = sd_dq_oe ? sd_dq_out : (chip_oe ? chip_dq : 16'hffff);
	assign pin_cmd = {sd_cs, sd_ras, sd_cas, sd_we};

	sdram_top #(.CAS_LATENCY(CAS_LATENCY), .REFRESH_SLOTS(REFRESH_SLOTS)) i_sdram_top (
		.clk_64, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel,
		.wb_dat_r, .wb_ack, .sd_dq_in(dq_bus), .sd_dq_out, .sd_dq_oe, .sd_addr, .sd_ba,
		.sd_dqm, .sd_cs, .sd_ras, .sd_cas, .sd_we);

	sdram_chip_model #(.CAS_LATENCY(CAS_LATENCY)) i_chip (.clk_64, .cs(sd_cs), .ras(sd_ras),
		.cas(sd_cas), .we(sd_we), .ba(sd_ba), .addr(sd_addr), .dqm(sd_dqm), .dq_in(dq_bus),
		.dq_out(chip_dq), .dq_oe(chip_oe));

	initial begin
		forever #50 clk_64 = ~clk_64;	// 100 ns period
	end

	function automatic logic [31:0] xorshift_next();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check(input logic ok, input string what);
		n_checks++;
		assert (ok) else begin
			n_errors++;
			$display("error at %0t ns: %s", $time, what);
		end
	endtask

	// --------------------
	// one wishbone cycle that updates or compares the reference word
	task automatic bus_access(input logic we, input int idx, input logic [15:0] data,
			input logic [1:0] sel);
		int cycles;
		cycles = 0;
		@(negedge clk_64);
		cur_adr  = pool_adr[idx];
		cur_we   = we;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = pool_adr[idx];
		wb_dat_w = data;
		wb_sel   = sel;
		do begin
			@(negedge clk_64);
			cycles++;
		end while (!wb_ack && cycles < ACK_TIMEOUT);
		if (!wb_ack) begin
			$display("timeout: no wishbone acknowledge within %0d cycles", ACK_TIMEOUT);
			timed_out = 1'b1;
		end else begin
			check(i_chip.n_precharge_all > 0 && i_chip.n_refresh >= 2
				&& i_chip.n_load_mode > 0, "acknowledge before the init sequence");
			if (!mode_checked) begin	// cl, single word bursts, single writes
				check(i_chip.mode_word[6:4] == 3'(CAS_LATENCY)
					&& i_chip.mode_word[3:0] == 4'h0 && i_chip.mode_word[9],
					$sformatf("mode word %h, expected cl %0d", i_chip.mode_word, CAS_LATENCY));
				mode_checked = 1'b1;
			end
			if (we) begin
				if (sel[0])
					ref_mem[idx][7:0] = data[7:0];
				if (sel[1])
					ref_mem[idx][15:8] = data[15:8];
			end else
				check(wb_dat_r == ref_mem[idx], $sformatf("read %h at %h, expected %h",
					wb_dat_r, cur_adr, ref_mem[idx]));
			// cycle stays up through the rising edge that samples ack
			@(negedge clk_64);
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			check(!wb_ack, "acknowledge wider than one cycle");
		end
	endtask

	// --------------------
	// pin monitor sampling the registered pins at the falling edge
	always @(negedge clk_64) begin
		if (!reset && pin_cmd == C_ACTIVE)
			check(sd_ba == cur_adr[23:22] && sd_addr == cur_adr[21:9],
				$sformatf("active bank %0d row %h for address %h", sd_ba, sd_addr, cur_adr));
		if (!reset && (pin_cmd == C_READ || pin_cmd == C_WRITE))
			check(sd_ba == cur_adr[23:22] && sd_addr[8:0] == cur_adr[8:0] && sd_addr[10]
				&& (pin_cmd == C_WRITE) == cur_we,
				$sformatf("column word %h bank %0d for address %h", sd_addr, sd_ba, cur_adr));
		if (sd_dq_oe || chip_oe)	// controller drives only with the write command
			check(!(sd_dq_oe && chip_oe) && (!sd_dq_oe || pin_cmd == C_WRITE),
				$sformatf("data bus oe %b, chip oe %b, cmd %b", sd_dq_oe, chip_oe, pin_cmd));
	end

	initial begin
		logic [31:0] r;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_sel   = '0;
		repeat (3) @(negedge clk_64);
		reset = 1'b0;
		for (int i = 0; i < POOL_SIZE; i++) begin
			r = xorshift_next();
			pool_adr[i] = {r[23:3], 3'(i)};	// distinct low bits
		end
		// full word writes first so every pooled word has a reference
		for (int i = 0; i < POOL_SIZE && !timed_out; i++) begin
			r = xorshift_next();
			bus_access(1'b1, i, r[15:0], 2'b11);
		end
		for (int n = 0; n < N_OPS && !timed_out; n++) begin
			r = xorshift_next();
			bus_access(r[0], int'(r[3:1]), r[31:16], r[5:4]);
		end
		check(i_chip.max_refresh_gap <= 8 * (REFRESH_SLOTS + 1)
			&& i_chip.refresh_gap <= 8 * (REFRESH_SLOTS + 1),
			$sformatf("refresh gap %0d cycles", i_chip.max_refresh_gap));
		check(i_chip.n_bad_seq == 0, $sformatf("%0d row sequence faults", i_chip.n_bad_seq));
		$display("%0d checks, %0d errors, %0d timeouts", n_checks, n_errors, timed_out);
		if (n_errors == 0 && !timed_out)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== sdram_top.f ====
source/sdram_pkg.sv
source/sdram_req_if.sv
source/sdram_wb_port.sv
source/sdram_sequencer.sv
source/sdram_addr_mux.sv
source/sdram_data_path.sv
source/sdram_init_refresh.sv
source/sdram_top.sv
tests/sdram_chip_model.sv
tests/sdram_top_tb.sv

// ==== Makefile ====
# Verilator build and run for the sdram controller testbench

VERILATOR ?= verilator
TOP       ?= sdram_top_tb
FILELIST  ?= sdram_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list the targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit 0
	@grep -q "ALL CHECKS PASSED" $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
